// File: dv/dcd_cases.txt
# inst pc rs1 rs2 flags(b jal jalr ld st csr mul div rem) jofs len prdt | mode op1 op2
# | ls_type aligned | op_a op_b res_sel | csr_addr upd_type mask | brc_pc_upd
002081B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 0 80000005 FFFFFFF0 0 1 180000005 1FFFFFFF0 0 002 0 00000000 00001004
402081B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 1 80000005 FFFFFFF0 0 1 180000005 1FFFFFFF0 0 402 0 00000000 00001004
0020A1B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 4 80000005 FFFFFFF0 2 0 180000005 0FFFFFFF0 1 002 1 80000005 00001004
0020B1B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 6 80000005 FFFFFFF0 3 0 080000005 0FFFFFFF0 1 002 2 7FFFFFFA 00001004
0020C1B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 8 80000005 FFFFFFF0 4 1 180000005 1FFFFFFF0 1 002 0 00000000 00001004
0020E1B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 9 80000005 FFFFFFF0 6 0 180000005 1FFFFFFF0 1 002 1 00000001 00001004
0020F1B3 00001000 80000005 FFFFFFF0 000000000 000000 1 1 a 80000005 FFFFFFF0 7 0 080000005 0FFFFFFF0 1 002 2 FFFFFFFE 00001004
idle
FF008193 00001000 80000005 FFFFFFF0 000000000 000000 1 1 0 80000005 FFFFFFF0 0 1 180000005 1FFFFFFF0 0 FF0 0 00000000 00001004
4070D193 00001000 80000005 FFFFFFF0 000000000 000000 1 1 d 80000005 00000007 5 1 080000005 0FFFFFFF0 1 407 0 00000001 00001004
0040D193 00001000 80000005 FFFFFFF0 000000000 000000 1 1 c 80000005 00000004 5 0 080000005 0FFFFFFF0 1 004 0 00000001 00001004
00309193 00001000 80000005 FFFFFFF0 000000000 000000 1 1 b 80000005 00000003 1 1 180000005 1FFFFFFF0 1 003 0 80000005 00001004
123451B7 00001000 80000005 FFFFFFF0 000000000 000000 1 1 0 00000000 12345000 5 1 080000005 0FFFFFFF0 1 123 0 00000008 00001004
FFFFF197 00001000 80000005 FFFFFFF0 000000000 000000 1 1 0 00001000 FFFFF000 7 0 080000005 0FFFFFFF0 1 FFF 2 FFFFFFE0 00001004
idle
100001EF 00001000 80000005 FFFFFFF0 010000000 000100 1 0 0 00001000 00000004 0 1 180000005 1FFFFFFF0 0 100 0 00000000 00001100
00208063 00002000 80000005 FFFFFFF0 100000000 1FFFF0 1 0 2 80000005 FFFFFFF0 0 1 180000005 1FFFFFFF0 0 002 0 00000000 00001FF0
0020E063 00002000 80000005 FFFFFFF0 100000000 000000 0 1 6 80000005 FFFFFFF0 6 0 180000005 1FFFFFFF0 1 002 1 00000001 00002002
0020D063 00002000 80000005 FFFFFFF0 100000000 000000 1 1 5 80000005 FFFFFFF0 5 0 080000005 0FFFFFFF0 1 002 0 00000001 00002004
idle
0030A183 00001000 80000005 FFFFFFF0 000100000 000000 1 1 0 80000005 00000003 2 1 180000005 0FFFFFFF0 1 003 1 80000005 00001004
00209183 00001000 80000005 FFFFFFF0 000100000 000000 1 1 0 80000005 00000002 1 0 180000005 1FFFFFFF0 1 002 0 80000005 00001004
FE20AFA3 00001000 80000005 FFFFFFF0 000010000 000000 1 1 0 80000005 FFFFFFFF 2 1 180000005 0FFFFFFF0 1 FE2 1 80000005 00001004
002082A3 00001000 80000005 FFFFFFF0 000010000 000000 1 1 0 80000005 00000005 0 1 180000005 1FFFFFFF0 0 002 0 00000000 00001004
002091A3 00001000 80000005 FFFFFFF0 000010000 000000 1 1 0 80000005 00000003 1 1 180000005 1FFFFFFF0 1 002 0 80000005 00001004
idle
022081B3 00001000 80000005 FFFFFFF0 000000100 000000 1 1 0 00000000 00000000 0 1 180000005 1FFFFFFF0 0 022 0 00000000 00001004
022091B3 00001000 80000005 FFFFFFF0 000000100 000000 1 1 0 00000000 00000000 1 0 180000005 1FFFFFFF0 1 022 0 80000005 00001004
0220A1B3 00001000 80000005 FFFFFFF0 000000100 000000 1 1 0 00000000 00000000 2 0 180000005 0FFFFFFF0 1 022 1 80000005 00001004
0220B1B3 00001000 80000005 FFFFFFF0 000000100 000000 1 1 0 00000000 00000000 3 0 080000005 0FFFFFFF0 1 022 2 7FFFFFFA 00001004
0220C1B3 00001000 80000005 FFFFFFF0 000000010 000000 1 1 0 00000000 00000000 4 1 180000005 1FFFFFFF0 1 022 0 00000000 00001004
0220D1B3 00001000 80000005 FFFFFFF0 000000010 000000 1 1 0 00000000 00000000 5 0 080000005 0FFFFFFF0 1 022 0 00000001 00001004
0220E1B3 00001000 80000005 FFFFFFF0 000000001 000000 1 1 0 00000000 00000000 6 0 180000005 1FFFFFFF0 1 022 1 00000001 00001004
0220F1B3 00001000 80000005 FFFFFFF0 000000001 000000 1 1 0 00000000 00000000 7 0 080000005 0FFFFFFF0 1 022 2 FFFFFFFE 00001004
idle
300091F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 1 0 180000005 1FFFFFFF0 1 300 0 80000005 00001004
3000A1F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 2 0 180000005 0FFFFFFF0 1 300 1 80000005 00001004
3000B1F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 3 0 080000005 0FFFFFFF0 1 300 2 7FFFFFFA 00001004
3000D1F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 5 0 080000005 0FFFFFFF0 1 300 0 00000001 00001004
3000E1F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 6 0 180000005 1FFFFFFF0 1 300 1 00000001 00001004
3000F1F3 00001000 80000005 FFFFFFF0 000001000 000000 1 1 0 00000000 00000000 7 0 080000005 0FFFFFFF0 1 300 2 FFFFFFFE 00001004

// File: dv/tb_rv_decode_stage.sv
module tb_rv_decode_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_dcd_pkg::*;

	localparam int DRAIN_TIMEOUT = 20; // cycles allowed for the last results

	logic clk;
	logic reset;
	logic inst_vld;
	inst_word_u inst;
	pre_dcd_msg_t pre_dcd;
	logic [31:0] pc_of_inst;
	logic [31:0] rs1_v;
	logic [31:0] rs2_v;
	logic prdt_jump;
	logic dcd_vld;
	dcd_res_t dcd_res;

	logic exp_vld; // valid expected one cycle after the input strobe
	dcd_res_t exp_q[$];
	dcd_res_t exp_res;
	dcd_res_t got_exp;
	integer seed;
	integer fd;
	int n;
	int idle_len;
	string line;

	// one case line, stimulus then expected results
	logic [31:0] f_inst;
	logic [31:0] f_pc;
	logic [31:0] f_rs1;
	logic [31:0] f_rs2;
	logic [8:0] f_flags;
	logic [20:0] f_jofs;
	logic f_len;
	logic f_prdt;
	logic [3:0] e_mode;
	logic [31:0] e_op1;
	logic [31:0] e_op2;
	logic [2:0] e_ls;
	logic e_al;
	logic [32:0] e_a;
	logic [32:0] e_b;
	logic e_sel;
	logic [11:0] e_addr;
	logic [1:0] e_upd;
	logic [31:0] e_mask;
	logic [31:0] e_brc;

	rv_decode_stage rv_decode_stage_inst (
		.clk(clk),
		.reset(reset),
		.inst_vld(inst_vld),
		.inst(inst),
		.pre_dcd(pre_dcd),
		.pc_of_inst(pc_of_inst),
		.rs1_v(rs1_v),
		.rs2_v(rs2_v),
		.prdt_jump(prdt_jump),
		.dcd_vld(dcd_vld),
		.dcd_res(dcd_res)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		exp_vld <= reset ? 1'b0 : inst_vld;
	end

	task automatic stop_on_error(input string why);
		$display("error: %s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_vld(input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_vld got %b expected %b", $time, got, exp);
			stop_on_error("valid strobe out of step with the inputs");
		end
	endtask

	task automatic check_alu(input alu_op_msg_t got, input alu_op_msg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_res.alu_op got %h expected %h", $time, got, exp);
			stop_on_error("wrong alu operation");
		end
	endtask

	task automatic check_lsu(input lsu_op_msg_t got, input lsu_op_msg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_res.lsu_op got %h expected %h", $time, got, exp);
			stop_on_error("wrong load/store operation");
		end
	endtask

	task automatic check_mul_div(input mul_div_op_msg_t got, input mul_div_op_msg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_res.mul_div_op got %h expected %h",
				$time, got, exp);
			stop_on_error("wrong multiply/divide operands");
		end
	endtask

	task automatic check_csr(input csr_op_msg_t got, input csr_op_msg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_res.csr_op got %h expected %h", $time, got, exp);
			stop_on_error("wrong csr operation");
		end
	endtask

	task automatic check_brc(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0d ns: dcd_res.brc_pc_upd got %h expected %h",
				$time, got, exp);
			stop_on_error("wrong branch-fix pc");
		end
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
	endtask

	// outputs are sampled mid-cycle, away from the driving edge
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_vld(dcd_vld, exp_vld);
			if (dcd_vld) begin
				if (exp_q.size() == 0)
					stop_on_error("result came out with no instruction pending");
				got_exp = exp_q.pop_front();
				check_alu(dcd_res.alu_op, got_exp.alu_op);
				check_lsu(dcd_res.lsu_op, got_exp.lsu_op);
				check_mul_div(dcd_res.mul_div_op, got_exp.mul_div_op);
				check_csr(dcd_res.csr_op, got_exp.csr_op);
				check_brc(dcd_res.brc_pc_upd, got_exp.brc_pc_upd);
			end
		end
	end

	initial begin
		seed = 32'h962b;
		clk = 1'b0;
		reset = 1'b1;
		inst_vld = 1'b0;
		inst = '0;
		pre_dcd = '0;
		pc_of_inst = 32'd0;
		rs1_v = 32'd0;
		rs2_v = 32'd0;
		prdt_jump = 1'b0;
		fd = $fopen("dv/dcd_cases.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open dv/dcd_cases.txt");
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk); // dcd_vld has to stay low here
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			if (line.substr(0, 3) == "idle") begin
				idle_len = ($random(seed) & 7) + 1;
				repeat (idle_len) begin
					@(posedge clk);
					inst_vld <= 1'b0;
				end
			end else begin
				n = $sscanf(line,
					"%h %h %h %h %b %h %b %b %h %h %h %h %b %h %h %b %h %h %h %h",
					f_inst, f_pc, f_rs1, f_rs2, f_flags, f_jofs, f_len, f_prdt,
					e_mode, e_op1, e_op2, e_ls, e_al, e_a, e_b, e_sel,
					e_addr, e_upd, e_mask, e_brc);
				if (n != 20)
					stop_on_error({"malformed case line: ", line});
				exp_res = '{
					alu_op: '{mode: e_mode, op1: e_op1, op2: e_op2},
					lsu_op: '{ls_type: e_ls, ls_addr_aligned: e_al},
					mul_div_op: '{op_a: e_a, op_b: e_b, res_sel: e_sel},
					csr_op: '{addr: e_addr, upd_type: e_upd, upd_mask_v: e_mask},
					brc_pc_upd: e_brc
				};
				@(posedge clk);
				inst_vld <= 1'b1;
				inst <= f_inst;
				pre_dcd <= pre_dcd_msg_t'({f_flags, f_jofs, f_len});
				pc_of_inst <= f_pc;
				rs1_v <= f_rs1;
				rs2_v <= f_rs2;
				prdt_jump <= f_prdt;
				exp_q.push_back(exp_res);
			end
		end
		$fclose(fd);
		@(posedge clk);
		inst_vld <= 1'b0;
		wait_results();
		if (exp_q.size() == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			stop_on_error("timeout waiting for dcd_vld to return the last results");
		end
	end

endmodule

// File: hdl/rv_alu_op_decoder.sv
module rv_alu_op_decoder (
	input  rv_dcd_pkg::inst_word_u inst,
	input  rv_dcd_pkg::pre_dcd_msg_t pre_dcd,
	input  logic [31:0] pc_of_inst,
	input  logic [31:0] rs1_v,
	input  logic [31:0] rs2_v,
	input  rv_dcd_pkg::imm_set_t imm,
	output rv_dcd_pkg::alu_op_msg_t alu_op
);
	import rv_dcd_pkg::*;

	logic [2:0] funct3;
	logic alt; // inst bit 30
	logic is_lui;
	logic is_auipc;
	logic is_jump;
	logic is_mem;
	logic is_arth_imm;
	logic is_arth_reg;
	logic [3:0] mode;
	logic [31:0] op1;
	logic [31:0] op2;

	assign funct3 = inst.r.funct3;
	assign alt = inst.r.funct7[5];

	assign is_lui = inst.r.opcode == OPCODE_LUI;
	assign is_auipc = inst.r.opcode == OPCODE_AUIPC;
	assign is_jump = pre_dcd.is_jal | pre_dcd.is_jalr;
	assign is_mem = pre_dcd.is_load | pre_dcd.is_store;
	assign is_arth_imm = inst.r.opcode == OPCODE_ARTH_IMM;
	assign is_arth_reg = (inst.r.opcode == OPCODE_ARTH_REG) & ~inst.r.funct7[0]; // no m-ext

	always_comb begin
		mode = ALU_ADD; // lui, auipc, jumps, load and store
		if (pre_dcd.is_b) begin
			case (funct3)
				3'b000: mode = ALU_EQU;
				3'b001: mode = ALU_NEQU;
				3'b100: mode = ALU_SGN_LT;
				3'b101: mode = ALU_SGN_GET;
				3'b110: mode = ALU_USGN_LT;
				3'b111: mode = ALU_USGN_GET;
				default: mode = ALU_ADD;
			endcase
		end else if (is_arth_imm | is_arth_reg) begin
			case (funct3)
				3'b000: mode = (is_arth_reg & alt) ? ALU_SUB : ALU_ADD;
				3'b001: mode = ALU_LG_LSH;
				3'b010: mode = ALU_SGN_LT;
				3'b011: mode = ALU_USGN_LT;
				3'b100: mode = ALU_XOR;
				3'b101: mode = alt ? ALU_ATH_RSH : ALU_LG_RSH;
				3'b110: mode = ALU_OR;
				default: mode = ALU_AND;
			endcase
		end
	end

	always_comb begin
		if (is_auipc | is_jump)
			op1 = pc_of_inst;
		else if (pre_dcd.is_b | is_mem | is_arth_imm | is_arth_reg)
			op1 = rs1_v;
		else
			op1 = 32'd0; // lui adds to zero
	end

	always_comb begin
		if (is_jump)
			op2 = 32'd4; // link address
		else if (is_lui | is_auipc)
			op2 = imm.load_reg_imm;
		else if (is_mem)
			op2 = imm.ls_ofs_imm;
		else if (is_arth_imm)
			op2 = imm.arth_imm;
		else if (pre_dcd.is_b | is_arth_reg)
			op2 = rs2_v;
		else
			op2 = 32'd0;
	end

	assign alu_op = '{mode: mode, op1: op1, op2: op2};

endmodule

// File: hdl/rv_csr_op_decoder.sv
module rv_csr_op_decoder (
	input  rv_dcd_pkg::inst_word_u inst,
	input  logic [31:0] rs1_v,
	input  logic [31:0] csr_upd_imm,
	output rv_dcd_pkg::csr_op_msg_t csr_op
);
	import rv_dcd_pkg::*;

	logic [1:0] upd_type;
	logic [31:0] upd_mask_v;

	always_comb begin
		case (inst.i.funct3)
			F3_CSRRW: begin
				upd_type = CSR_UPD_LOAD;
				upd_mask_v = rs1_v;
			end
			F3_CSRRWI: begin
				upd_type = CSR_UPD_LOAD;
				upd_mask_v = csr_upd_imm;
			end
			F3_CSRRS: begin
				upd_type = CSR_UPD_SET;
				upd_mask_v = rs1_v;
			end
			F3_CSRRSI: begin
				upd_type = CSR_UPD_SET;
				upd_mask_v = csr_upd_imm;
			end
			F3_CSRRC: begin
				upd_type = CSR_UPD_CLR;
				upd_mask_v = ~rs1_v; // and-mask for clear
			end
			F3_CSRRCI: begin
				upd_type = CSR_UPD_CLR;
				upd_mask_v = ~csr_upd_imm;
			end
			default: begin
				upd_type = CSR_UPD_LOAD;
				upd_mask_v = 32'd0;
			end
		endcase
	end

	assign csr_op = '{addr: inst.i.imm, upd_type: upd_type, upd_mask_v: upd_mask_v};

endmodule

// File: hdl/rv_dcd_pkg.sv
package rv_dcd_pkg;

	// major opcodes
	localparam logic [6:0] OPCODE_LUI = 7'b0110111;
	localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR = 7'b1100111;
	localparam logic [6:0] OPCODE_B = 7'b1100011;
	localparam logic [6:0] OPCODE_LD = 7'b0000011;
	localparam logic [6:0] OPCODE_STR = 7'b0100011;
	localparam logic [6:0] OPCODE_ARTH_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_ARTH_REG = 7'b0110011;
	localparam logic [6:0] OPCODE_ENV_CSR = 7'b1110011;

	// alu modes
	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_EQU = 4'd2;
	localparam logic [3:0] ALU_NEQU = 4'd3;
	localparam logic [3:0] ALU_SGN_LT = 4'd4;
	localparam logic [3:0] ALU_SGN_GET = 4'd5; // signed >=
	localparam logic [3:0] ALU_USGN_LT = 4'd6;
	localparam logic [3:0] ALU_USGN_GET = 4'd7; // unsigned >=
	localparam logic [3:0] ALU_XOR = 4'd8;
	localparam logic [3:0] ALU_OR = 4'd9;
	localparam logic [3:0] ALU_AND = 4'd10;
	localparam logic [3:0] ALU_LG_LSH = 4'd11;
	localparam logic [3:0] ALU_LG_RSH = 4'd12;
	localparam logic [3:0] ALU_ATH_RSH = 4'd13;

	// access types, same encoding as funct3
	localparam logic [2:0] LS_BYTE = 3'b000;
	localparam logic [2:0] LS_HALF = 3'b001;
	localparam logic [2:0] LS_WORD = 3'b010;
	localparam logic [2:0] LS_BYTE_U = 3'b100;
	localparam logic [2:0] LS_HALF_U = 3'b101;

	localparam logic [1:0] CSR_UPD_LOAD = 2'b00;
	localparam logic [1:0] CSR_UPD_SET = 2'b01;
	localparam logic [1:0] CSR_UPD_CLR = 2'b10;

	localparam logic [2:0] F3_SHIFT_R = 3'b101; // srli and srai
	localparam logic [2:0] F3_MUL = 3'b000;
	localparam logic [2:0] F3_MULHSU = 3'b010;
	localparam logic [2:0] F3_MULHU = 3'b011;
	localparam logic [2:0] F3_DIVU = 3'b101;
	localparam logic [2:0] F3_REMU = 3'b111;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [2:0] F3_CSRRC = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} inst_word_u;

	typedef struct packed {
		logic is_b;
		logic is_jal;
		logic is_jalr;
		logic is_load;
		logic is_store;
		logic is_csr_rw;
		logic is_mul;
		logic is_div;
		logic is_rem;
		logic [20:0] jump_ofs_imm;
		logic inst_len_type; // 1 for 32-bit, 0 for 16-bit
	} pre_dcd_msg_t;

	typedef struct packed {
		logic [31:0] load_reg_imm;
		logic [31:0] ls_ofs_imm;
		logic [31:0] arth_imm;
		logic [31:0] csr_upd_imm;
	} imm_set_t;

	typedef struct packed {
		logic [3:0] mode;
		logic [31:0] op1;
		logic [31:0] op2;
	} alu_op_msg_t;

	typedef struct packed {
		logic [2:0] ls_type;
		logic ls_addr_aligned;
	} lsu_op_msg_t;

	typedef struct packed {
		logic [32:0] op_a;
		logic [32:0] op_b;
		logic res_sel; // 1 selects the high product word
	} mul_div_op_msg_t;

	typedef struct packed {
		logic [11:0] addr;
		logic [1:0] upd_type;
		logic [31:0] upd_mask_v;
	} csr_op_msg_t;

	typedef struct packed {
		alu_op_msg_t alu_op;
		lsu_op_msg_t lsu_op;
		mul_div_op_msg_t mul_div_op;
		csr_op_msg_t csr_op;
		logic [31:0] brc_pc_upd;
	} dcd_res_t;

endpackage

// File: hdl/rv_decode_stage.sv
module rv_decode_stage (
	input  logic clk,
	input  logic reset,
	input  logic inst_vld,
	input  rv_dcd_pkg::inst_word_u inst,
	input  rv_dcd_pkg::pre_dcd_msg_t pre_dcd,
	input  logic [31:0] pc_of_inst,
	input  logic [31:0] rs1_v,
	input  logic [31:0] rs2_v,
	input  logic prdt_jump,
	output logic dcd_vld,
	output rv_dcd_pkg::dcd_res_t dcd_res
);
	import rv_dcd_pkg::*;

	imm_set_t imm;
	alu_op_msg_t alu_op;
	lsu_op_msg_t lsu_op;
	mul_div_op_msg_t mul_div_op;
	csr_op_msg_t csr_op;
	logic [31:0] brc_ofs;
	logic [31:0] brc_pc_upd;

	rv_imm_decoder rv_imm_decoder_inst (
		.inst(inst),
		.is_store(pre_dcd.is_store),
		.imm(imm)
	);

	rv_alu_op_decoder rv_alu_op_decoder_inst (
		.inst(inst),
		.pre_dcd(pre_dcd),
		.pc_of_inst(pc_of_inst),
		.rs1_v(rs1_v),
		.rs2_v(rs2_v),
		.imm(imm),
		.alu_op(alu_op)
	);

	rv_lsu_op_decoder rv_lsu_op_decoder_inst (
		.inst(inst),
		.rs1_v(rs1_v),
		.ls_ofs_imm(imm.ls_ofs_imm),
		.lsu_op(lsu_op)
	);

	rv_mul_div_op_decoder rv_mul_div_op_decoder_inst (
		.inst(inst),
		.rs1_v(rs1_v),
		.rs2_v(rs2_v),
		.mul_div_op(mul_div_op)
	);

	rv_csr_op_decoder rv_csr_op_decoder_inst (
		.inst(inst),
		.rs1_v(rs1_v),
		.csr_upd_imm(imm.csr_upd_imm),
		.csr_op(csr_op)
	);

	// predicted taken means a miss falls through to the next instruction
	assign brc_ofs = prdt_jump ? (32'd2 << pre_dcd.inst_len_type) :
		{{11{pre_dcd.jump_ofs_imm[20]}}, pre_dcd.jump_ofs_imm};
	assign brc_pc_upd = pc_of_inst + brc_ofs;

	always_ff @(posedge clk) begin
		if (reset)
			dcd_vld <= 1'b0;
		else
			dcd_vld <= inst_vld;
	end

	always_ff @(posedge clk) begin
		if (inst_vld) begin
			dcd_res <= '{
				alu_op: alu_op,
				lsu_op: lsu_op,
				mul_div_op: mul_div_op,
				csr_op: csr_op,
				brc_pc_upd: brc_pc_upd
			};
		end
	end

	// one result per accepted instruction, one cycle later
	property p_vld_follows_inst;
		@(posedge clk) disable iff (reset)
			!$past(reset) |-> (dcd_vld == $past(inst_vld));
	endproperty
	a_vld_follows_inst: assert property (p_vld_follows_inst);

	property p_load_store_exclusive;
		@(posedge clk) disable iff (reset)
			inst_vld |-> !(pre_dcd.is_load && pre_dcd.is_store);
	endproperty
	a_load_store_exclusive: assert property (p_load_store_exclusive);

endmodule

// File: hdl/rv_imm_decoder.sv
module rv_imm_decoder (
	input  rv_dcd_pkg::inst_word_u inst,
	input  logic is_store,
	output rv_dcd_pkg::imm_set_t imm
);
	import rv_dcd_pkg::*;

	logic shift_r;
	logic [4:0] ofs_lo;
	logic [11:0] arth_field;

	assign shift_r = inst.i.funct3 == F3_SHIFT_R;

	// store keeps its low offset bits where a load has rd
	assign ofs_lo = is_store ? inst.s.imm_lo : inst.r.rs2;

	// drop the srai marker bit so shamt stays clean
	assign arth_field = inst.i.imm & {1'b1, ~shift_r, 10'h3ff};

	assign imm = '{
		load_reg_imm: {inst.u.imm, 12'd0},
		ls_ofs_imm: {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, ofs_lo},
		arth_imm: {{20{arth_field[11]}}, arth_field},
		csr_upd_imm: {27'd0, inst.i.rs1} // zimm in the rs1 slot
	};

endmodule

// File: hdl/rv_lsu_op_decoder.sv
module rv_lsu_op_decoder (
	input  rv_dcd_pkg::inst_word_u inst,
	input  logic [31:0] rs1_v,
	input  logic [31:0] ls_ofs_imm,
	output rv_dcd_pkg::lsu_op_msg_t lsu_op
);
	import rv_dcd_pkg::*;

	logic [2:0] ls_type;
	logic [1:0] addr_lo; // low address bits only
	logic aligned;

	assign ls_type = inst.i.funct3;
	assign addr_lo = rs1_v[1:0] + ls_ofs_imm[1:0];

	always_comb begin
		case (ls_type)
			LS_BYTE, LS_BYTE_U: aligned = 1'b1;
			LS_HALF, LS_HALF_U: aligned = ~addr_lo[0];
			LS_WORD: aligned = addr_lo == 2'b00;
			default: aligned = 1'b0;
		endcase
	end

	assign lsu_op = '{ls_type: ls_type, ls_addr_aligned: aligned};

endmodule

// File: hdl/rv_mul_div_op_decoder.sv
module rv_mul_div_op_decoder (
	input  rv_dcd_pkg::inst_word_u inst,
	input  logic [31:0] rs1_v,
	input  logic [31:0] rs2_v,
	output rv_dcd_pkg::mul_div_op_msg_t mul_div_op
);
	import rv_dcd_pkg::*;

	logic [2:0] funct3;
	logic a_unsigned;
	logic b_unsigned;

	assign funct3 = inst.r.funct3;

	assign a_unsigned = (funct3 == F3_MULHU) | (funct3 == F3_DIVU) | (funct3 == F3_REMU);
	// mulhsu takes rs2 as unsigned only
	assign b_unsigned = a_unsigned | (funct3 == F3_MULHSU);

	assign mul_div_op = '{
		op_a: {~a_unsigned & rs1_v[31], rs1_v},
		op_b: {~b_unsigned & rs2_v[31], rs2_v},
		res_sel: funct3 != F3_MUL // low word for mul
	};

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_rv_decode_stage \
	-f sources.f \
	-o sim_rv_decode_stage

./obj_dir/sim_rv_decode_stage

// File: sources.f
hdl/rv_dcd_pkg.sv
hdl/rv_imm_decoder.sv
hdl/rv_alu_op_decoder.sv
hdl/rv_lsu_op_decoder.sv
hdl/rv_mul_div_op_decoder.sv
hdl/rv_csr_op_decoder.sv
hdl/rv_decode_stage.sv
dv/tb_rv_decode_stage.sv
